// File: include/hci_consts.svh
// Widths, queue depths, register word addresses and field positions of the HCI core
// Included by the package and by every RTL file that decodes registers or sizes queues
`ifndef HCI_CONSTS_SVH
`define HCI_CONSTS_SVH

`define HCI_CMD_DEPTH  16
`define HCI_RESP_DEPTH 16

`define HCI_DATA_W 32
`define HCI_CSR_AW 8
`define HCI_QCNT_W 5  // Holds 0 to depth
`define HCI_THLD_W 8
`define HCI_DEV_AW 7

`define HCI_REG_RESET_CONTROL   8'h08
`define HCI_REG_QUEUE_THLD_CTRL 8'h10
`define HCI_REG_COMMAND_PORT    8'h14
`define HCI_REG_RESPONSE_PORT   8'h15
`define HCI_REG_QUEUE_STATUS    8'h16
`define HCI_REG_DEVICE_ADDR     8'h20

`define HCI_RST_CMD_BIT       1
`define HCI_RST_RESP_BIT      2
`define HCI_THLD_CMD_LSB      0
`define HCI_THLD_RESP_LSB     8
`define HCI_STAT_CMD_LSB      0  // Free slots
`define HCI_STAT_RESP_LSB     8  // Stored words
`define HCI_DA_ADDR_LSB       0
`define HCI_DA_VALID_BIT      15
`define HCI_DA_VIRT_LSB       16
`define HCI_DA_VIRT_VALID_BIT 31

`endif

// File: logic/hci_pkg.sv
// Vector types shared by the HCI RTL and its testbench
// Widths come from the constants header
`include "hci_consts.svh"

package hci_pkg;

  // Word address on the register port
  typedef logic [`HCI_CSR_AW-1:0] csr_addr_t;

  // Register and queue data word
  typedef logic [`HCI_DATA_W-1:0] csr_data_t;

  // Queue occupancy, 0 up to the full depth
  typedef logic [`HCI_QCNT_W-1:0] qdepth_t;

  typedef logic [`HCI_THLD_W-1:0] thld_t;

  // I3C 7-bit device address
  typedef logic [`HCI_DEV_AW-1:0] dev_addr_t;

endpackage

// File: logic/hci_if.sv
// Internal links between the register block and the queues and address control
// One hci_queue_if per queue, one hci_addr_if for the address registers

interface hci_queue_if;
  logic               req;         // One-cycle push or pop strobe
  hci_pkg::csr_data_t wdata;
  hci_pkg::thld_t     thld;
  logic               flush;
  hci_pkg::csr_data_t rdata;       // Head word
  logic               err;         // Strobed request refused
  hci_pkg::qdepth_t   count;
  logic               flush_done;

  modport csr (
    output req, wdata, thld, flush,
    input  rdata, err, count, flush_done
  );

  modport queue (
    input  req, wdata, thld, flush,
    output rdata, err, count, flush_done
  );
endinterface

interface hci_addr_if;
  hci_pkg::dev_addr_t dyn_addr;
  logic               dyn_valid;
  hci_pkg::dev_addr_t virt_addr;
  logic               virt_valid;

  modport ctrl (
    output dyn_addr, dyn_valid, virt_addr, virt_valid
  );

  modport csr (
    input dyn_addr, dyn_valid, virt_addr, virt_valid
  );
endinterface

// File: logic/hci_queue.sv
// Circular word queue between the register port and the bus controller
// PortWrites=1 lets software push (command), PortWrites=0 lets the controller push (response)
module hci_queue #(
  parameter int unsigned Depth      = 16,
  parameter bit          PortWrites = 1'b1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               hw_valid_i,
  input  hci_pkg::csr_data_t hw_data_i,
  input  logic               hw_ready_i,
  output logic               hw_valid_o,
  output hci_pkg::csr_data_t hw_data_o,
  output logic               hw_ready_o,
  output logic               thld_trig_o,
  hci_queue_if.queue         port
);

  localparam int unsigned      PtrW     = $clog2(Depth);
  localparam hci_pkg::qdepth_t DepthCnt = hci_pkg::qdepth_t'(Depth);

  hci_pkg::csr_data_t mem [Depth];
  logic [PtrW-1:0]    wr_ptr_q;
  logic [PtrW-1:0]    rd_ptr_q;
  hci_pkg::qdepth_t   count_q;
  logic               flush_done_q;
  logic               empty;
  logic               full;
  logic               push_req;
  logic               pop_req;
  logic               push;
  logic               pop;
  hci_pkg::csr_data_t push_data;
  hci_pkg::thld_t     level;

  assign empty = (count_q == '0);
  assign full  = (count_q == DepthCnt);

  // Select the pushing and the popping side
  always_comb begin
    if (PortWrites) begin
      push_req  = port.req;
      push_data = port.wdata;
      pop_req   = hw_ready_i;
    end else begin
      push_req  = hw_valid_i;
      push_data = hw_data_i;
      pop_req   = port.req;
    end
  end

  assign push     = push_req & ~full;
  assign pop      = pop_req & ~empty;
  assign port.err = port.req & (PortWrites ? full : empty);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      flush_done_q <= 1'b0;
    end else begin
      flush_done_q <= port.flush & ~flush_done_q;  // Single pulse per flush
      if (port.flush) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
        if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
        count_q <= count_q + hci_pkg::qdepth_t'(push) - hci_pkg::qdepth_t'(pop);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr_q] <= push_data;
  end

  // Free slots on the command side, stored words on the response side
  assign level = PortWrites ? hci_pkg::thld_t'(DepthCnt - count_q)
                            : hci_pkg::thld_t'(count_q);
  assign thld_trig_o = (level >= port.thld);

  assign hw_valid_o      = ~empty;
  assign hw_ready_o      = ~full;
  assign hw_data_o       = mem[rd_ptr_q];
  assign port.rdata      = mem[rd_ptr_q];
  assign port.count      = count_q;
  assign port.flush_done = flush_done_q;

  a_count_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= DepthCnt);

  // A software request in a flush cycle would be dropped
  a_no_req_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    port.flush |-> !port.req);

endmodule

// File: logic/hci_csr.sv
// Register port decode for the HCI core with threshold and queue reset registers
// Routes COMMAND_PORT and RESPONSE_PORT accesses to the queues, acknowledges one cycle later
`include "hci_consts.svh"

module hci_csr (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               csr_req_i,
  input  logic               csr_wr_i,
  input  hci_pkg::csr_addr_t csr_addr_i,
  input  hci_pkg::csr_data_t csr_wdata_i,
  output logic               csr_rd_ack_o,
  output logic               csr_wr_ack_o,
  output logic               csr_err_o,
  output hci_pkg::csr_data_t csr_rdata_o,
  hci_queue_if.csr           cmd_q,
  hci_queue_if.csr           resp_q,
  hci_addr_if.csr            addr
);

  // Thresholds above the queue depth could never trigger
  function automatic hci_pkg::thld_t clamp_thld(hci_pkg::thld_t val, int unsigned depth);
    return (val > depth) ? hci_pkg::thld_t'(depth) : val;
  endfunction

  logic               rd_ack_q;
  logic               wr_ack_q;
  logic               err_q;
  hci_pkg::csr_data_t rdata_q;
  hci_pkg::thld_t     cmd_thld_q;
  hci_pkg::thld_t     resp_thld_q;
  logic               cmd_rst_q;
  logic               resp_rst_q;
  logic               err_d;
  hci_pkg::csr_data_t rdata_d;
  logic               thld_we;
  logic               rstc_we;
  hci_pkg::qdepth_t   cmd_free;

  assign cmd_free = hci_pkg::qdepth_t'(`HCI_CMD_DEPTH) - cmd_q.count;

  // Port strobes, held off while the queue is flushing
  assign cmd_q.req  = csr_req_i && csr_wr_i && !cmd_rst_q &&
                      (csr_addr_i == `HCI_REG_COMMAND_PORT);
  assign resp_q.req = csr_req_i && !csr_wr_i && !resp_rst_q &&
                      (csr_addr_i == `HCI_REG_RESPONSE_PORT);

  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    thld_we = 1'b0;
    rstc_we = 1'b0;
    if (csr_req_i) begin
      case (csr_addr_i)
        `HCI_REG_RESET_CONTROL: begin
          rdata_d[`HCI_RST_CMD_BIT]  = cmd_rst_q;
          rdata_d[`HCI_RST_RESP_BIT] = resp_rst_q;
          rstc_we = csr_wr_i;
        end
        `HCI_REG_QUEUE_THLD_CTRL: begin
          rdata_d[`HCI_THLD_CMD_LSB +: `HCI_THLD_W]  = cmd_thld_q;
          rdata_d[`HCI_THLD_RESP_LSB +: `HCI_THLD_W] = resp_thld_q;
          thld_we = csr_wr_i;
        end
        `HCI_REG_COMMAND_PORT: begin
          err_d = !csr_wr_i || cmd_rst_q || cmd_q.err;  // Write-only
        end
        `HCI_REG_RESPONSE_PORT: begin
          rdata_d = resp_q.rdata;
          err_d   = csr_wr_i || resp_rst_q || resp_q.err;  // Read-only
        end
        `HCI_REG_QUEUE_STATUS: begin
          rdata_d[`HCI_STAT_CMD_LSB +: `HCI_THLD_W]  = hci_pkg::thld_t'(cmd_free);
          rdata_d[`HCI_STAT_RESP_LSB +: `HCI_THLD_W] = hci_pkg::thld_t'(resp_q.count);
          err_d = csr_wr_i;
        end
        `HCI_REG_DEVICE_ADDR: begin
          rdata_d[`HCI_DA_ADDR_LSB +: `HCI_DEV_AW] = addr.dyn_addr;
          rdata_d[`HCI_DA_VALID_BIT]               = addr.dyn_valid;
          rdata_d[`HCI_DA_VIRT_LSB +: `HCI_DEV_AW] = addr.virt_addr;
          rdata_d[`HCI_DA_VIRT_VALID_BIT]          = addr.virt_valid;
          err_d = csr_wr_i;
        end
        default: err_d = csr_wr_i;
      endcase
      // Refused pop returns zero
      if (err_d) rdata_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_q    <= 1'b0;
      wr_ack_q    <= 1'b0;
      err_q       <= 1'b0;
      cmd_thld_q  <= hci_pkg::thld_t'(1);
      resp_thld_q <= hci_pkg::thld_t'(1);
      cmd_rst_q   <= 1'b0;
      resp_rst_q  <= 1'b0;
    end else begin
      rd_ack_q <= csr_req_i & ~csr_wr_i;
      wr_ack_q <= csr_req_i & csr_wr_i;
      err_q    <= err_d;
      if (thld_we) begin
        cmd_thld_q  <= clamp_thld(csr_wdata_i[`HCI_THLD_CMD_LSB +: `HCI_THLD_W],
                                  `HCI_CMD_DEPTH);
        resp_thld_q <= clamp_thld(csr_wdata_i[`HCI_THLD_RESP_LSB +: `HCI_THLD_W],
                                  `HCI_RESP_DEPTH);
      end
      // Self-clearing once the queue reports the flush
      if (cmd_q.flush_done) cmd_rst_q <= 1'b0;
      if (resp_q.flush_done) resp_rst_q <= 1'b0;
      if (rstc_we && csr_wdata_i[`HCI_RST_CMD_BIT]) cmd_rst_q <= 1'b1;
      if (rstc_we && csr_wdata_i[`HCI_RST_RESP_BIT]) resp_rst_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (csr_req_i && !csr_wr_i) rdata_q <= rdata_d;
  end

  assign cmd_q.wdata  = csr_wdata_i;
  assign resp_q.wdata = csr_wdata_i;  // Unused by a controller-fed queue
  assign cmd_q.thld   = cmd_thld_q;
  assign resp_q.thld  = resp_thld_q;
  assign cmd_q.flush  = cmd_rst_q;
  assign resp_q.flush = resp_rst_q;

  assign csr_rd_ack_o = rd_ack_q;
  assign csr_wr_ack_o = wr_ack_q;
  assign csr_err_o    = err_q;
  assign csr_rdata_o  = rdata_q;

  // A queue reports a flush only while its reset bit is set
  a_flush_done_in_rst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!cmd_q.flush_done || cmd_rst_q) && (!resp_q.flush_done || resp_rst_q));

endmodule

// File: logic/hci_addr_ctrl.sv
// Dynamic and virtual device address registers
// Updated one edge after a SETDASA, RSTDAA or SETNEWDA event from the bus side
module hci_addr_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  hci_pkg::dev_addr_t set_dasa_i,
  input  logic               set_dasa_valid_i,
  input  logic               set_dasa_virtual_device_i,
  input  logic               rstdaa_i,
  input  hci_pkg::dev_addr_t newda_i,
  input  logic               set_newda_i,
  input  logic               set_newda_virtual_device_i,
  hci_addr_if.ctrl           addr
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr.dyn_addr   <= '0;
      addr.dyn_valid  <= 1'b0;
      addr.virt_addr  <= '0;
      addr.virt_valid <= 1'b0;
    end else if (set_dasa_valid_i || rstdaa_i) begin
      // RSTDAA wins over SETDASA
      if (set_dasa_virtual_device_i) begin
        addr.virt_addr  <= rstdaa_i ? '0 : set_dasa_i;
        addr.virt_valid <= !rstdaa_i;
      end else begin
        addr.dyn_addr  <= rstdaa_i ? '0 : set_dasa_i;
        addr.dyn_valid <= !rstdaa_i;
      end
    end else if (set_newda_i) begin
      if (set_newda_virtual_device_i) begin
        addr.virt_addr  <= newda_i;
        addr.virt_valid <= 1'b1;
      end else begin
        addr.dyn_addr  <= newda_i;
        addr.dyn_valid <= 1'b1;
      end
    end
  end

  // Event inputs come straight from the bus FSMs
  a_events_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({set_dasa_i, set_dasa_valid_i, set_dasa_virtual_device_i, rstdaa_i,
                 newda_i, set_newda_i, set_newda_virtual_device_i}));

endmodule

// File: logic/hci.sv
// Programmed-I/O core of an I3C host controller interface
// Register port for software, command and response queues toward the bus controller
`include "hci_consts.svh"

module hci (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               csr_req_i,
  input  logic               csr_wr_i,
  input  hci_pkg::csr_addr_t csr_addr_i,
  input  hci_pkg::csr_data_t csr_wdata_i,
  output logic               csr_rd_ack_o,
  output logic               csr_wr_ack_o,
  output logic               csr_err_o,
  output hci_pkg::csr_data_t csr_rdata_o,
  output logic               cmd_rvalid_o,
  input  logic               cmd_rready_i,
  output hci_pkg::csr_data_t cmd_rdata_o,
  output logic               cmd_thld_trig_o,
  output hci_pkg::qdepth_t   cmd_depth_o,
  input  logic               resp_wvalid_i,
  output logic               resp_wready_o,
  input  hci_pkg::csr_data_t resp_wdata_i,
  output logic               resp_thld_trig_o,
  output hci_pkg::qdepth_t   resp_depth_o,
  input  hci_pkg::dev_addr_t set_dasa_i,
  input  logic               set_dasa_valid_i,
  input  logic               set_dasa_virtual_device_i,
  input  logic               rstdaa_i,
  input  hci_pkg::dev_addr_t newda_i,
  input  logic               set_newda_i,
  input  logic               set_newda_virtual_device_i
);

  hci_queue_if cmd_if ();
  hci_queue_if resp_if ();
  hci_addr_if  addr_if ();

  hci_csr u_csr (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_wr_i,
    .csr_addr_i,
    .csr_wdata_i,
    .csr_rd_ack_o,
    .csr_wr_ack_o,
    .csr_err_o,
    .csr_rdata_o,
    .cmd_q  (cmd_if.csr),
    .resp_q (resp_if.csr),
    .addr   (addr_if.csr)
  );

  // Software pushes, controller drains
  hci_queue #(
    .Depth      (`HCI_CMD_DEPTH),
    .PortWrites (1'b1)
  ) cmd_queue (
    .clk_i,
    .rst_ni,
    .hw_valid_i  (1'b0),
    .hw_data_i   ('0),
    .hw_ready_i  (cmd_rready_i),
    .hw_valid_o  (cmd_rvalid_o),
    .hw_data_o   (cmd_rdata_o),
    .hw_ready_o  (),
    .thld_trig_o (cmd_thld_trig_o),
    .port        (cmd_if.queue)
  );

  // Controller fills, software pops
  hci_queue #(
    .Depth      (`HCI_RESP_DEPTH),
    .PortWrites (1'b0)
  ) resp_queue (
    .clk_i,
    .rst_ni,
    .hw_valid_i  (resp_wvalid_i),
    .hw_data_i   (resp_wdata_i),
    .hw_ready_i  (1'b0),
    .hw_valid_o  (),
    .hw_data_o   (),
    .hw_ready_o  (resp_wready_o),
    .thld_trig_o (resp_thld_trig_o),
    .port        (resp_if.queue)
  );

  hci_addr_ctrl u_addr_ctrl (
    .clk_i,
    .rst_ni,
    .set_dasa_i,
    .set_dasa_valid_i,
    .set_dasa_virtual_device_i,
    .rstdaa_i,
    .newda_i,
    .set_newda_i,
    .set_newda_virtual_device_i,
    .addr (addr_if.ctrl)
  );

  assign cmd_depth_o  = cmd_if.count;
  assign resp_depth_o = resp_if.count;

endmodule

// File: dv/hci_tb.sv
// Self-checking testbench for the HCI core against a queue and address model
// Random register accesses, controller traffic and address events from a fixed seed
`include "hci_consts.svh"

module hci_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CmdDepth   = `HCI_CMD_DEPTH;
  localparam int RespDepth  = `HCI_RESP_DEPTH;
  localparam int TestCycles = 2000;  // Rough length of all tests
  localparam int MaxCycles  = 2 * TestCycles;

  logic               clk_i;
  logic               rst_ni;
  logic               csr_req_i;
  logic               csr_wr_i;
  hci_pkg::csr_addr_t csr_addr_i;
  hci_pkg::csr_data_t csr_wdata_i;
  logic               csr_rd_ack_o;
  logic               csr_wr_ack_o;
  logic               csr_err_o;
  hci_pkg::csr_data_t csr_rdata_o;
  logic               cmd_rvalid_o;
  logic               cmd_rready_i;
  hci_pkg::csr_data_t cmd_rdata_o;
  logic               cmd_thld_trig_o;
  hci_pkg::qdepth_t   cmd_depth_o;
  logic               resp_wvalid_i;
  logic               resp_wready_o;
  hci_pkg::csr_data_t resp_wdata_i;
  logic               resp_thld_trig_o;
  hci_pkg::qdepth_t   resp_depth_o;
  hci_pkg::dev_addr_t set_dasa_i;
  logic               set_dasa_valid_i;
  logic               set_dasa_virtual_device_i;
  logic               rstdaa_i;
  hci_pkg::dev_addr_t newda_i;
  logic               set_newda_i;
  logic               set_newda_virtual_device_i;

  // Reference model
  hci_pkg::csr_data_t cmd_model[$];
  hci_pkg::csr_data_t resp_model[$];
  hci_pkg::thld_t     cmd_thld = 8'd1;
  hci_pkg::thld_t     resp_thld = 8'd1;
  hci_pkg::dev_addr_t model_dyn_addr = '0;
  logic               model_dyn_valid = 1'b0;
  hci_pkg::dev_addr_t model_virt_addr = '0;
  logic               model_virt_valid = 1'b0;

  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned cycles = 0;

  hci dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Run stopped after %0d cycles without reaching the end of the tests", MaxCycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_data(input string name, input hci_pkg::csr_data_t exp,
                            input hci_pkg::csr_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_depth(input string name, input hci_pkg::qdepth_t exp,
                             input hci_pkg::qdepth_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input hci_pkg::dev_addr_t exp,
                            input hci_pkg::dev_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic hci_pkg::thld_t limit_thld(hci_pkg::thld_t val, int depth);
    return (int'(val) > depth) ? hci_pkg::thld_t'(depth) : val;
  endfunction

  function automatic hci_pkg::csr_data_t thld_word();
    return {16'h0, resp_thld, cmd_thld};
  endfunction

  function automatic hci_pkg::csr_data_t status_word();
    return {16'h0, 8'(resp_model.size()), 8'(CmdDepth - cmd_model.size())};
  endfunction

  function automatic bit is_mapped(hci_pkg::csr_addr_t a);
    return a inside {`HCI_REG_RESET_CONTROL, `HCI_REG_QUEUE_THLD_CTRL, `HCI_REG_COMMAND_PORT,
                     `HCI_REG_RESPONSE_PORT, `HCI_REG_QUEUE_STATUS, `HCI_REG_DEVICE_ADDR};
  endfunction

  // One register access, request on a falling edge, acknowledge expected a cycle later
  task automatic csr_access(input logic wr, input hci_pkg::csr_addr_t addr,
                            input hci_pkg::csr_data_t wdata,
                            output hci_pkg::csr_data_t rdata, output logic err);
    @(negedge clk_i);
    csr_req_i   = 1'b1;
    csr_wr_i    = wr;
    csr_addr_i  = addr;
    csr_wdata_i = wdata;
    @(negedge clk_i);
    csr_req_i = 1'b0;
    check_flag("write ack", wr, csr_wr_ack_o);
    check_flag("read ack", !wr, csr_rd_ack_o);
    rdata = csr_rdata_o;
    err   = csr_err_o;
  endtask

  task automatic check_status(input string name);
    check_depth({name, " cmd depth"}, hci_pkg::qdepth_t'(cmd_model.size()), cmd_depth_o);
    check_depth({name, " resp depth"}, hci_pkg::qdepth_t'(resp_model.size()), resp_depth_o);
    check_flag({name, " cmd trigger"}, (CmdDepth - cmd_model.size()) >= int'(cmd_thld),
               cmd_thld_trig_o);
    check_flag({name, " resp trigger"}, resp_model.size() >= int'(resp_thld),
               resp_thld_trig_o);
  endtask

  task automatic push_command(input hci_pkg::csr_data_t word);
    hci_pkg::csr_data_t rd;
    logic               err;
    logic               exp_err;
    exp_err = (cmd_model.size() == CmdDepth);
    csr_access(1'b1, `HCI_REG_COMMAND_PORT, word, rd, err);
    check_flag("command push error", exp_err, err);
    if (!exp_err) cmd_model.push_back(word);
    check_status("command push");
  endtask

  task automatic drain_cycle(input logic ready);
    @(negedge clk_i);
    cmd_rready_i = ready;
    check_flag("cmd_rvalid", cmd_model.size() != 0, cmd_rvalid_o);
    if (cmd_model.size() != 0) check_data("command order", cmd_model[0], cmd_rdata_o);
    if (ready && cmd_model.size() != 0) void'(cmd_model.pop_front());
    @(negedge clk_i);
    cmd_rready_i = 1'b0;
    check_status("command drain");
  endtask

  task automatic push_response(input hci_pkg::csr_data_t word);
    @(negedge clk_i);
    resp_wvalid_i = 1'b1;
    resp_wdata_i  = word;
    check_flag("resp_wready", resp_model.size() < RespDepth, resp_wready_o);
    if (resp_model.size() < RespDepth) resp_model.push_back(word);
    @(negedge clk_i);
    resp_wvalid_i = 1'b0;
    check_status("response push");
  endtask

  task automatic pop_response();
    hci_pkg::csr_data_t rd;
    hci_pkg::csr_data_t exp;
    logic               err;
    logic               exp_err;
    exp_err = (resp_model.size() == 0);
    exp     = exp_err ? '0 : resp_model.pop_front();
    csr_access(1'b0, `HCI_REG_RESPONSE_PORT, '0, rd, err);
    check_flag("response pop error", exp_err, err);
    check_data("response order", exp, rd);
    check_status("response pop");
  endtask

  task automatic compare_device_addr(input string name);
    hci_pkg::csr_data_t rd;
    logic               err;
    csr_access(1'b0, `HCI_REG_DEVICE_ADDR, '0, rd, err);
    check_flag({name, " read error"}, 1'b0, err);
    check_addr({name, " dynamic address"}, model_dyn_addr, rd[`HCI_DA_ADDR_LSB +: 7]);
    check_flag({name, " dynamic valid"}, model_dyn_valid, rd[`HCI_DA_VALID_BIT]);
    check_addr({name, " virtual address"}, model_virt_addr, rd[`HCI_DA_VIRT_LSB +: 7]);
    check_flag({name, " virtual valid"}, model_virt_valid, rd[`HCI_DA_VIRT_VALID_BIT]);
  endtask

  task automatic compare_reg(input string name, input hci_pkg::csr_addr_t addr,
                             input hci_pkg::csr_data_t exp);
    hci_pkg::csr_data_t rd;
    logic               err;
    csr_access(1'b0, addr, '0, rd, err);
    check_flag({name, " read error"}, 1'b0, err);
    check_data(name, exp, rd);
  endtask

  task automatic write_thresholds();
    hci_pkg::csr_data_t wd;
    hci_pkg::csr_data_t rd;
    logic               err;
    wd = $urandom();
    wd[7:0]  = hci_pkg::thld_t'($urandom_range(24));  // Some above the depth
    wd[15:8] = hci_pkg::thld_t'($urandom_range(24));
    csr_access(1'b1, `HCI_REG_QUEUE_THLD_CTRL, wd, rd, err);
    check_flag("threshold write error", 1'b0, err);
    cmd_thld  = limit_thld(wd[7:0], CmdDepth);
    resp_thld = limit_thld(wd[15:8], RespDepth);
    check_status("threshold write");
    compare_reg("threshold readback", `HCI_REG_QUEUE_THLD_CTRL, thld_word());
  endtask

  task automatic flush_queue(input int bit_pos);
    hci_pkg::csr_data_t wd;
    hci_pkg::csr_data_t rd;
    logic               err;
    wd = '0;
    wd[bit_pos] = 1'b1;
    csr_access(1'b1, `HCI_REG_RESET_CONTROL, wd, rd, err);
    check_flag("queue reset write error", 1'b0, err);
    if (bit_pos == `HCI_RST_CMD_BIT) cmd_model.delete();
    else resp_model.delete();
    @(negedge clk_i);  // Flush edge, bit clears at the next one
    compare_reg("reset bits", `HCI_REG_RESET_CONTROL, '0);
    check_status("queue reset");
    compare_reg("queue status", `HCI_REG_QUEUE_STATUS, status_word());
  endtask

  task automatic address_event();
    logic               dasa_v;
    logic               rstdaa;
    logic               newda_v;
    logic               dasa_virt;
    logic               newda_virt;
    hci_pkg::dev_addr_t dasa;
    hci_pkg::dev_addr_t newda;
    dasa_v     = ($urandom_range(2) == 0);
    rstdaa     = ($urandom_range(3) == 0);
    newda_v    = ($urandom_range(1) == 1);
    dasa_virt  = ($urandom_range(1) == 1);
    newda_virt = ($urandom_range(1) == 1);
    dasa       = hci_pkg::dev_addr_t'($urandom());
    newda      = hci_pkg::dev_addr_t'($urandom());
    @(negedge clk_i);
    set_dasa_i                 = dasa;
    set_dasa_valid_i           = dasa_v;
    set_dasa_virtual_device_i  = dasa_virt;
    rstdaa_i                   = rstdaa;
    newda_i                    = newda;
    set_newda_i                = newda_v;
    set_newda_virtual_device_i = newda_virt;
    @(negedge clk_i);
    set_dasa_valid_i = 1'b0;
    rstdaa_i         = 1'b0;
    set_newda_i      = 1'b0;
    // SETDASA or RSTDAA first, RSTDAA clears the target
    if (dasa_v || rstdaa) begin
      if (dasa_virt) begin
        model_virt_addr  = rstdaa ? '0 : dasa;
        model_virt_valid = !rstdaa;
      end else begin
        model_dyn_addr  = rstdaa ? '0 : dasa;
        model_dyn_valid = !rstdaa;
      end
    end else if (newda_v) begin
      if (newda_virt) begin
        model_virt_addr  = newda;
        model_virt_valid = 1'b1;
      end else begin
        model_dyn_addr  = newda;
        model_dyn_valid = 1'b1;
      end
    end
    compare_device_addr("address event");
  endtask

  task automatic bad_accesses();
    hci_pkg::csr_addr_t addr;
    hci_pkg::csr_data_t rd;
    logic               err;
    repeat (8) begin
      do addr = hci_pkg::csr_addr_t'($urandom()); while (is_mapped(addr));
      csr_access(1'b1, addr, $urandom(), rd, err);
      check_flag("unknown address write error", 1'b1, err);
    end
    csr_access(1'b1, `HCI_REG_QUEUE_STATUS, $urandom(), rd, err);
    check_flag("QUEUE_STATUS write error", 1'b1, err);
    csr_access(1'b1, `HCI_REG_DEVICE_ADDR, $urandom(), rd, err);
    check_flag("DEVICE_ADDR write error", 1'b1, err);
    csr_access(1'b1, `HCI_REG_RESPONSE_PORT, $urandom(), rd, err);
    check_flag("RESPONSE_PORT write error", 1'b1, err);
    csr_access(1'b0, `HCI_REG_COMMAND_PORT, '0, rd, err);
    check_flag("COMMAND_PORT read error", 1'b1, err);
    check_data("COMMAND_PORT read data", '0, rd);
    check_status("bad access");
    compare_reg("threshold after bad access", `HCI_REG_QUEUE_THLD_CTRL, thld_word());
    compare_reg("reset bits after bad access", `HCI_REG_RESET_CONTROL, '0);
    compare_device_addr("address after bad access");
  endtask

  initial begin
    void'($urandom(32'h7b042aac));
    rst_ni                     = 1'b0;
    csr_req_i                  = 1'b0;
    csr_wr_i                   = 1'b0;
    csr_addr_i                 = '0;
    csr_wdata_i                = '0;
    cmd_rready_i               = 1'b0;
    resp_wvalid_i              = 1'b0;
    resp_wdata_i               = '0;
    set_dasa_i                 = '0;
    set_dasa_valid_i           = 1'b0;
    set_dasa_virtual_device_i  = 1'b0;
    rstdaa_i                   = 1'b0;
    newda_i                    = '0;
    set_newda_i                = 1'b0;
    set_newda_virtual_device_i = 1'b0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    // Idle outputs after reset
    @(negedge clk_i);
    check_flag("read ack after reset", 1'b0, csr_rd_ack_o);
    check_flag("write ack after reset", 1'b0, csr_wr_ack_o);
    check_flag("error after reset", 1'b0, csr_err_o);
    check_flag("cmd_rvalid after reset", 1'b0, cmd_rvalid_o);
    check_flag("resp_wready after reset", 1'b1, resp_wready_o);
    check_status("after reset");
    compare_reg("threshold after reset", `HCI_REG_QUEUE_THLD_CTRL, thld_word());
    compare_reg("reset bits after reset", `HCI_REG_RESET_CONTROL, '0);
    compare_device_addr("address after reset");

    repeat (60) begin
      if ($urandom_range(2) != 0) push_command($urandom());
      else drain_cycle($urandom_range(1) == 1);
    end
    while (cmd_model.size() != 0) drain_cycle($urandom_range(1) == 1);

    repeat (RespDepth + 2) push_response($urandom());  // Last two refused
    repeat (RespDepth + 1) pop_response();

    repeat (12) begin
      write_thresholds();
      repeat ($urandom_range(3)) push_command($urandom());
      repeat ($urandom_range(3)) push_response($urandom());
    end

    push_command($urandom());
    push_response($urandom());
    flush_queue(`HCI_RST_CMD_BIT);
    push_command($urandom());  // Must survive the response flush
    flush_queue(`HCI_RST_RESP_BIT);

    repeat (30) address_event();
    push_response($urandom());
    bad_accesses();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
logic/hci_pkg.sv
logic/hci_if.sv
logic/hci_queue.sv
logic/hci_csr.sv
logic/hci_addr_ctrl.sv
logic/hci.sv
dv/hci_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = hci_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
